//--- compile.f
+incdir+.
icache_pkg.sv
icache_bram.sv
icache_way.sv
icache.sv
icache_top.sv
icache_checker.sv
icache_tb.sv

//--- icache.sv
`include "icache_settings.svh"

module icache (
    input  logic              clk,
    input  logic              reset,
    input  logic              fetch_en,
    input  logic              uncache_en,
    input  icache_pkg::addr_t pc,
    input  logic              branch_flush,
    output logic              stall,
    output logic              inst_valid,
    output logic              inst_b_valid,
    output icache_pkg::word_t inst_a,
    output icache_pkg::word_t inst_b,
    output icache_pkg::addr_t pc_out,
    output logic              rd_req,
    output icache_pkg::addr_t rd_addr,
    input  logic              ret_valid,
    input  icache_pkg::line_t ret_data,
    output logic              flush_out,
    output logic              uc_ren,
    output icache_pkg::addr_t uc_addr,
    input  logic              uc_rvalid,
    input  icache_pkg::word_t uc_rdata
);
    import icache_pkg::*;

    icache_state_t state, next_state;

    addr_t  pc_b;
    addr_t  req_pc_a, req_pc_b;
    logic   req_uncached;
    logic   same_line;
    logic   accept;
    logic   lookup_valid;
    logic   lookup_act;
    logic   lookup_miss;
    logic   b_miss_rec;
    logic   flush_d;
    logic   drop_ret;
    logic   real_ret;
    logic   uc_done;

    logic   clearing;
    index_t clr_cnt;

    index_t idx_a, idx_b;
    addr_t  refill_pc;
    index_t refill_idx;
    tag_t   wr_tag;
    logic   victim;
    logic   refill_wr;
    logic   we0_a, we0_b, we1_a, we1_b;
    logic   [`ICACHE_SET_NUM-1:0] lru;   // per set, the way to replace next

    line_t  line0_a, line0_b, line1_a, line1_b;
    logic   [`ICACHE_TAG_SIZE:0] tagv0_a, tagv0_b, tagv1_a, tagv1_b;
    logic   hit0_a, hit1_a, hit0_b, hit1_b;
    logic   hit_a, hit_b;
    word_t  word_a, word_b;

    logic   out_valid;
    word_t  out_inst_a, out_inst_b;
    addr_t  out_pc;

    assign pc_b   = pc + 32'd4;
    assign accept = fetch_en && !stall;

    always_ff @(posedge clk) begin
        if (accept) begin
            req_pc_a     <= pc;
            req_pc_b     <= pc_b;
            req_uncached <= uncache_en;
            same_line    <= (pc[`ICACHE_TAG_LOC] == pc_b[`ICACHE_TAG_LOC]) &&
                            (pc[`ICACHE_INDEX_LOC] == pc_b[`ICACHE_INDEX_LOC]);
        end
    end

    // a return is wasted if its request was abandoned by a flush
    assign real_ret = ret_valid && !drop_ret && !branch_flush;

    assign lookup_act  = lookup_valid && !req_uncached && !branch_flush && !flush_d;
    assign lookup_miss = lookup_valid && !flush_d && (req_uncached || !hit_a || !hit_b);

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= idle;
            lookup_valid <= 1'b0;
            b_miss_rec   <= 1'b0;
            flush_d      <= 1'b0;
            drop_ret     <= 1'b0;
            out_valid    <= 1'b0;
            clearing     <= 1'b1;
            clr_cnt      <= '0;
        end else begin
            state        <= next_state;
            // anything taken in the flush cycle is wrong path
            lookup_valid <= (accept || state == refill_done) && !branch_flush;
            flush_d      <= branch_flush;
            out_valid    <= lookup_act && hit_a && hit_b;
            if (lookup_act) begin
                b_miss_rec <= !hit_b;
            end
            if (branch_flush && rd_req && !ret_valid) begin
                drop_ret <= 1'b1;
            end else if (ret_valid) begin
                drop_ret <= 1'b0;
            end
            if (clearing) begin
                clr_cnt <= clr_cnt + 1'b1;
                if (clr_cnt == index_t'(`ICACHE_SET_NUM - 1)) begin
                    clearing <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            idle: begin
                if (lookup_valid) begin
                    if (req_uncached) next_state = uncache_wait;
                    else if (!hit_a)  next_state = ask_mem_a;
                    else if (!hit_b)  next_state = ask_mem_b;
                end
            end
            ask_mem_a: begin
                if (real_ret) begin
                    // one line covers both slots, or b already hit
                    next_state = (same_line || !b_miss_rec) ? refill_done : ask_mem_b;
                end
            end
            ask_mem_b: begin
                if (real_ret) next_state = refill_done;
            end
            refill_done:  next_state = idle;   // lookup again
            uncache_wait: begin
                if (uc_rvalid) next_state = idle;
            end
            default: next_state = idle;
        endcase
        if (branch_flush || flush_d) begin
            next_state = idle;
        end
    end

    assign stall = clearing || (!branch_flush && (state != idle || lookup_miss));

    // refill bus
    assign refill_pc  = (state == ask_mem_b) ? req_pc_b : req_pc_a;
    assign refill_idx = refill_pc[`ICACHE_INDEX_LOC];
    assign wr_tag     = refill_pc[`ICACHE_TAG_LOC];
    assign rd_req     = (state == ask_mem_a || state == ask_mem_b) && !drop_ret;
    assign rd_addr    = {refill_pc[`ICACHE_ADDR_SIZE-1:`ICACHE_OFFSET_SIZE],
                         {`ICACHE_OFFSET_SIZE{1'b0}}};
    assign flush_out  = branch_flush;

    assign victim    = lru[refill_idx];
    assign refill_wr = real_ret && rd_req;

    // slot a line goes through port a, slot b line through port b
    assign we0_a = clearing || (refill_wr && state == ask_mem_a && !victim);
    assign we1_a = clearing || (refill_wr && state == ask_mem_a && victim);
    assign we0_b = clearing || (refill_wr && state == ask_mem_b && !victim);
    assign we1_b = clearing || (refill_wr && state == ask_mem_b && victim);

    assign idx_a = clearing ? clr_cnt :
                   accept   ? pc[`ICACHE_INDEX_LOC] : req_pc_a[`ICACHE_INDEX_LOC];
    assign idx_b = clearing ? clr_cnt :
                   accept   ? pc_b[`ICACHE_INDEX_LOC] : req_pc_b[`ICACHE_INDEX_LOC];

    icache_way u_way0 (
        .clk     (clk),
        .addra   (idx_a),
        .addrb   (idx_b),
        .wea     (we0_a),
        .web     (we0_b),
        .line_in (ret_data),
        .tag_in  (wr_tag),
        .data_a  (line0_a),
        .data_b  (line0_b),
        .tagv_a  (tagv0_a),
        .tagv_b  (tagv0_b)
    );

    icache_way u_way1 (
        .clk     (clk),
        .addra   (idx_a),
        .addrb   (idx_b),
        .wea     (we1_a),
        .web     (we1_b),
        .line_in (ret_data),
        .tag_in  (wr_tag),
        .data_a  (line1_a),
        .data_b  (line1_b),
        .tagv_a  (tagv1_a),
        .tagv_b  (tagv1_b)
    );

    assign hit0_a = tagv0_a[`ICACHE_TAG_SIZE] &&
                    (tagv0_a[`ICACHE_TAG_SIZE-1:0] == req_pc_a[`ICACHE_TAG_LOC]);
    assign hit1_a = tagv1_a[`ICACHE_TAG_SIZE] &&
                    (tagv1_a[`ICACHE_TAG_SIZE-1:0] == req_pc_a[`ICACHE_TAG_LOC]);
    assign hit0_b = tagv0_b[`ICACHE_TAG_SIZE] &&
                    (tagv0_b[`ICACHE_TAG_SIZE-1:0] == req_pc_b[`ICACHE_TAG_LOC]);
    assign hit1_b = tagv1_b[`ICACHE_TAG_SIZE] &&
                    (tagv1_b[`ICACHE_TAG_SIZE-1:0] == req_pc_b[`ICACHE_TAG_LOC]);
    assign hit_a  = hit0_a || hit1_a;
    assign hit_b  = hit0_b || hit1_b;

    assign word_a = hit0_a ?
        line0_a[req_pc_a[`ICACHE_BANK_LOC]*`ICACHE_DATA_SIZE +: `ICACHE_DATA_SIZE] :
        line1_a[req_pc_a[`ICACHE_BANK_LOC]*`ICACHE_DATA_SIZE +: `ICACHE_DATA_SIZE];
    assign word_b = hit0_b ?
        line0_b[req_pc_b[`ICACHE_BANK_LOC]*`ICACHE_DATA_SIZE +: `ICACHE_DATA_SIZE] :
        line1_b[req_pc_b[`ICACHE_BANK_LOC]*`ICACHE_DATA_SIZE +: `ICACHE_DATA_SIZE];

    always_ff @(posedge clk) begin
        if (reset) begin
            lru <= '0;
        end else if (refill_wr) begin
            lru[refill_idx] <= !victim;
        end else if (lookup_act) begin
            if (hit_a) lru[req_pc_a[`ICACHE_INDEX_LOC]] <= hit0_a;
            if (hit_b) lru[req_pc_b[`ICACHE_INDEX_LOC]] <= hit0_b;   // b last
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_act) begin
            out_inst_a <= word_a;
            out_inst_b <= word_b;
            out_pc     <= req_pc_a;
        end
    end

    // uncached word passes straight through in the cycle it returns
    assign uc_done = (state == uncache_wait) && uc_rvalid && !branch_flush;
    assign uc_ren  = (state == uncache_wait) && !branch_flush;
    assign uc_addr = req_pc_a;

    assign inst_valid   = uc_done || (out_valid && !branch_flush);
    assign inst_b_valid = out_valid && !branch_flush;
    assign inst_a       = (state == uncache_wait) ? uc_rdata : out_inst_a;
    assign inst_b       = out_inst_b;
    assign pc_out       = (state == uncache_wait) ? req_pc_a : out_pc;

endmodule

//--- icache_bram.sv
`include "icache_settings.svh"

module icache_bram (
    input  logic               clk,
    input  logic               wea,
    input  icache_pkg::index_t addra,
    input  icache_pkg::word_t  dina,
    output icache_pkg::word_t  douta,
    input  logic               web,
    input  icache_pkg::index_t addrb,
    input  icache_pkg::word_t  dinb,
    output icache_pkg::word_t  doutb
);
    import icache_pkg::*;

    word_t mem [`ICACHE_SET_NUM];

    // both ports in one process, reads see the old word
    always_ff @(posedge clk) begin
        if (wea) begin
            mem[addra] <= dina;
        end
        douta <= mem[addra];

        if (web) begin
            mem[addrb] <= dinb;
        end
        doutb <= mem[addrb];
    end

endmodule

//--- icache_checker.sv
`include "icache_settings.svh"

module icache_checker (
    input  logic              clk,
    input  logic              reset,
    input  logic              fetch_en,
    input  logic              uncache_en,
    input  icache_pkg::addr_t pc,
    input  logic              branch_flush,
    input  logic              stall,
    input  logic              inst_valid,
    input  logic              inst_b_valid,
    input  icache_pkg::word_t inst_a,
    input  icache_pkg::word_t inst_b,
    input  icache_pkg::addr_t pc_out,
    input  logic              rd_req,
    input  icache_pkg::addr_t rd_addr,
    input  logic              ret_valid,
    input  logic              flush_out,
    input  logic              uc_ren,
    input  icache_pkg::addr_t uc_addr,
    output int                errors,
    output int                results,
    output int                refills,
    output int                pending
);
    timeunit 1ns;
    timeprecision 1ps;
    import icache_pkg::*;

    addr_t fetch_pc [$];    // accepted, waiting for inst_valid
    logic  fetch_uc [$];
    addr_t ret_lines [$];   // lines returned for the fetch in flight

    logic [`ICACHE_ADDR_SIZE-`ICACHE_OFFSET_SIZE-1:0] way_line [`ICACHE_SET_NUM][2];
    logic  way_ok [`ICACHE_SET_NUM][2];
    logic  lru_way [`ICACHE_SET_NUM];   // way to replace next
    logic  model_on;                    // off after the first flush
    logic  flush_last;
    logic  first_cycle;

    function automatic word_t expected_word(input addr_t addr);
        return addr ^ 32'hc0de_0000;
    endfunction

    function automatic addr_t line_base(input addr_t addr);
        return {addr[`ICACHE_ADDR_SIZE-1:`ICACHE_OFFSET_SIZE], {`ICACHE_OFFSET_SIZE{1'b0}}};
    endfunction

    // returns 1 on a miss and installs the line in the victim way
    function automatic logic touch_line(input addr_t addr);
        int set;
        int w;
        int victim;
        set = addr[`ICACHE_INDEX_LOC];
        for (w = 0; w < 2; w++) begin
            if (way_ok[set][w] &&
                way_line[set][w] == addr[`ICACHE_ADDR_SIZE-1:`ICACHE_OFFSET_SIZE]) begin
                lru_way[set] = (w == 0);
                return 1'b0;
            end
        end
        victim = lru_way[set];
        way_ok[set][victim]   = 1'b1;
        way_line[set][victim] = addr[`ICACHE_ADDR_SIZE-1:`ICACHE_OFFSET_SIZE];
        lru_way[set] = (victim == 0);
        return 1'b1;
    endfunction

    task automatic check_value(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: expected %h got %h at %0t", name, exp, got, $time);
        end
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("failure at %0t: %s", $time, what);
    endtask

    task automatic check_result();
        addr_t exp_lines [$];
        addr_t fpc;
        logic  fuc;
        fpc = fetch_pc.pop_front();
        fuc = fetch_uc.pop_front();
        results++;
        check_value("pc_out", pc_out, fpc);
        if (fuc) begin
            check_value("inst_a", inst_a, ~expected_word(fpc));
            check_value("inst_b_valid", word_t'(inst_b_valid), 32'h0);
            check_value("uc_addr", uc_addr, fpc);
            if (ret_lines.size() != 0) begin
                report_failure("an uncached fetch caused a refill request");
            end
        end else begin
            check_value("inst_a", inst_a, expected_word(fpc));
            check_value("inst_b", inst_b, expected_word(fpc + 32'd4));
            check_value("inst_b_valid", word_t'(inst_b_valid), 32'h1);
            if (model_on) begin
                // slot a first, a shared line then hits for slot b
                if (touch_line(fpc)) exp_lines.push_back(line_base(fpc));
                if (touch_line(fpc + 32'd4)) exp_lines.push_back(line_base(fpc + 32'd4));
                if (exp_lines.size() != ret_lines.size()) begin
                    errors++;
                    $display("ERROR rd_req count: expected %h got %h for pc %h",
                             exp_lines.size(), ret_lines.size(), fpc);
                end else begin
                    foreach (ret_lines[i]) check_value("rd_addr", ret_lines[i], exp_lines[i]);
                end
            end
        end
        ret_lines.delete();
    endtask

    always @(posedge clk) begin
        if (reset) begin
            fetch_pc.delete();
            fetch_uc.delete();
            ret_lines.delete();
            for (int s = 0; s < `ICACHE_SET_NUM; s++) begin
                way_ok[s][0] = 1'b0;
                way_ok[s][1] = 1'b0;
                lru_way[s]   = 1'b0;
            end
            model_on    = 1'b1;
            flush_last  = 1'b0;
            first_cycle = 1'b1;
            errors      = 0;
            results     = 0;
            refills     = 0;
        end else begin
            if (first_cycle) begin
                check_value("stall", word_t'(stall), 32'h1);   // tag clear pass
                check_value("rd_req", word_t'(rd_req), 32'h0);
                check_value("uc_ren", word_t'(uc_ren), 32'h0);
                check_value("inst_valid", word_t'(inst_valid), 32'h0);
                first_cycle = 1'b0;
            end
            check_value("flush_out", word_t'(flush_out), word_t'(branch_flush));
            if (ret_valid && rd_req) begin
                ret_lines.push_back(rd_addr);
                refills++;
            end
            if (inst_valid) begin
                if (branch_flush || flush_last) begin
                    report_failure("inst_valid in a flush cycle or the cycle after it");
                end else if (fetch_pc.size() == 0) begin
                    report_failure("inst_valid with no fetch outstanding");
                end else begin
                    check_result();
                end
            end
            if (branch_flush) begin
                // everything in flight is abandoned, a fetch taken now too
                fetch_pc.delete();
                fetch_uc.delete();
                ret_lines.delete();
                model_on = 1'b0;
            end else if (fetch_en && !stall) begin
                fetch_pc.push_back(pc);
                fetch_uc.push_back(uncache_en);
            end
            flush_last = branch_flush;
        end
        pending = fetch_pc.size();
    end

endmodule

//--- icache_pkg.sv
`include "icache_settings.svh"

package icache_pkg;

    typedef logic [`ICACHE_ADDR_SIZE-1:0] addr_t;    // byte address
    typedef logic [`ICACHE_DATA_SIZE-1:0] word_t;    // one instruction

    // refill line, word 0 sits in the low bits
    typedef logic [`ICACHE_BANK_NUM*`ICACHE_DATA_SIZE-1:0] line_t;

    typedef logic [`ICACHE_TAG_SIZE-1:0]   tag_t;
    typedef logic [`ICACHE_INDEX_SIZE-1:0] index_t;

    // miss handling steps through slot a, then slot b
    typedef enum logic [2:0] {
        idle,          // lookup or waiting for a request
        ask_mem_a,     // refill of the line holding pc
        ask_mem_b,     // refill of the line holding pc+4
        refill_done,   // bram written, read again
        uncache_wait   // single word from the uncached port
    } icache_state_t;

endpackage

//--- icache_settings.svh
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// widths
`define ICACHE_ADDR_SIZE    32
`define ICACHE_DATA_SIZE    32

// address split, tag | index | offset
`define ICACHE_TAG_SIZE     20
`define ICACHE_INDEX_SIZE   7
`define ICACHE_OFFSET_SIZE  5

// line geometry
`define ICACHE_BANK_NUM     8   // words per line
`define ICACHE_SET_NUM      128

// field positions in a byte address
`define ICACHE_TAG_LOC      31:12
`define ICACHE_INDEX_LOC    11:5
`define ICACHE_BANK_LOC     4:2   // word within the line

`endif

//--- icache_tb.sv
`include "icache_settings.svh"

module icache_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import icache_pkg::*;

    localparam int  NUM_FETCHES = 400;
    localparam real CLK_PERIOD  = 40.0;

    logic  clk;
    logic  reset;
    logic  fetch_en, uncache_en, branch_flush;
    addr_t pc;
    logic  stall, inst_valid, inst_b_valid;
    word_t inst_a, inst_b;
    addr_t pc_out;
    logic  rd_req, ret_valid, flush_out;
    addr_t rd_addr;
    line_t ret_data;
    logic  uc_ren, uc_rvalid;
    addr_t uc_addr;
    word_t uc_rdata;

    logic flush_phase;   // flushes only in the second half
    int   errors, results, refills, pending;

    icache_top UUT (
        .clk (clk), .reset (reset),
        .fetch_en (fetch_en), .uncache_en (uncache_en), .pc (pc),
        .branch_flush (branch_flush), .stall (stall),
        .inst_valid (inst_valid), .inst_b_valid (inst_b_valid),
        .inst_a (inst_a), .inst_b (inst_b), .pc_out (pc_out),
        .rd_req (rd_req), .rd_addr (rd_addr), .ret_valid (ret_valid),
        .ret_data (ret_data), .flush_out (flush_out),
        .uc_ren (uc_ren), .uc_addr (uc_addr), .uc_rvalid (uc_rvalid), .uc_rdata (uc_rdata)
    );

    icache_checker u_checker (
        .clk (clk), .reset (reset),
        .fetch_en (fetch_en), .uncache_en (uncache_en), .pc (pc),
        .branch_flush (branch_flush), .stall (stall),
        .inst_valid (inst_valid), .inst_b_valid (inst_b_valid),
        .inst_a (inst_a), .inst_b (inst_b), .pc_out (pc_out),
        .rd_req (rd_req), .rd_addr (rd_addr), .ret_valid (ret_valid),
        .flush_out (flush_out), .uc_ren (uc_ren), .uc_addr (uc_addr),
        .errors (errors), .results (results), .refills (refills), .pending (pending)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic word_t mem_word(input addr_t addr);
        return addr ^ 32'hc0de_0000;
    endfunction

    function automatic line_t make_line(input addr_t base);
        line_t line;
        int    i;
        for (i = 0; i < `ICACHE_BANK_NUM; i++) begin
            line[i*`ICACHE_DATA_SIZE +: `ICACHE_DATA_SIZE] = mem_word(base + addr_t'(4 * i));
        end
        return line;
    endfunction

    // three tags over four sets, so two ways keep getting evicted
    function automatic addr_t pick_pc();
        tag_t       tag;
        index_t     set;
        logic [2:0] word;
        case ($urandom_range(2))
            0:       tag = 20'h00010;
            1:       tag = 20'h2a5c3;
            default: tag = 20'h7f001;
        endcase
        case ($urandom_range(3))
            0:       set = 7'd3;
            1:       set = 7'd4;
            2:       set = 7'd64;
            default: set = 7'd127;   // pc+4 wraps to set 0
        endcase
        word = ($urandom_range(3) == 0) ? 3'd7 : 3'($urandom_range(7));
        return {tag, set, word, 2'b00};
    endfunction

    // refill memory, uncached responder and flush source
    task automatic serve_ports();
        int    mem_wait;
        int    uc_wait;
        logic  mem_busy;
        logic  uc_busy;
        addr_t mem_addr;
        mem_busy = 1'b0;
        uc_busy  = 1'b0;
        forever begin
            @(negedge clk);
            ret_valid = 1'b0;
            uc_rvalid = 1'b0;
            if (reset) begin
                mem_busy     = 1'b0;
                uc_busy      = 1'b0;
                branch_flush = 1'b0;
            end else begin
                if (mem_busy) begin
                    mem_wait--;
                    if (mem_wait == 0) begin   // returned even if flushed meanwhile
                        ret_valid = 1'b1;
                        ret_data  = make_line(mem_addr);
                        mem_busy  = 1'b0;
                    end
                end else if (rd_req) begin
                    mem_busy = 1'b1;
                    mem_addr = rd_addr;
                    mem_wait = $urandom_range(8, 1);
                end
                if (uc_busy) begin
                    if (!uc_ren) begin
                        uc_busy = 1'b0;   // abandoned by a flush
                    end else begin
                        uc_wait--;
                        if (uc_wait == 0) begin
                            uc_rvalid = 1'b1;
                            uc_rdata  = ~mem_word(uc_addr);
                            uc_busy   = 1'b0;
                        end
                    end
                end else if (uc_ren) begin
                    uc_busy = 1'b1;
                    uc_wait = $urandom_range(4, 1);
                end
                branch_flush = flush_phase && ($urandom_range(19) == 0);
            end
        end
    endtask

    // pc and enables are held while stall is high
    task automatic run_fetches(input int count);
        int   issued;
        logic took;
        issued = 0;
        while (issued < count) begin
            @(posedge clk);
            took = fetch_en && !stall;
            if (took) issued++;
            flush_phase = (issued >= count / 2) && (issued < count);
            @(negedge clk);
            if (took || !fetch_en) begin
                if (issued < count && $urandom_range(3) != 0) begin
                    fetch_en   = 1'b1;
                    pc         = pick_pc();
                    uncache_en = ($urandom_range(9) == 0);
                end else begin
                    fetch_en   = 1'b0;
                    uncache_en = 1'b0;
                end
            end
        end
    endtask

    initial begin
        int seed_out;
        seed_out     = $urandom(32'h57ee_4dfa);
        clk          = 1'b0;
        reset        = 1'b1;
        fetch_en     = 1'b0;
        uncache_en   = 1'b0;
        pc           = '0;
        branch_flush = 1'b0;
        ret_valid    = 1'b0;
        ret_data     = '0;
        uc_rvalid    = 1'b0;
        uc_rdata     = '0;
        flush_phase  = 1'b0;
        fork
            serve_ports();
        join_none
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        run_fetches(NUM_FETCHES);
        do begin
            @(negedge clk);
        end while (pending != 0);
        repeat (10) @(negedge clk);   // let late returns pass
        $display("errors %0d, results %0d, refills %0d", errors, results, refills);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #(NUM_FETCHES * 40 * CLK_PERIOD);
        $display("timeout: fetches still outstanding, errors %0d, results %0d",
                 errors, results);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- icache_top.sv
module icache_top (
    input  logic              clk,
    input  logic              reset,
    // front end
    input  logic              fetch_en,
    input  logic              uncache_en,
    input  icache_pkg::addr_t pc,
    input  logic              branch_flush,
    output logic              stall,
    output logic              inst_valid,
    output logic              inst_b_valid,
    output icache_pkg::word_t inst_a,
    output icache_pkg::word_t inst_b,
    output icache_pkg::addr_t pc_out,
    // refill bus
    output logic              rd_req,
    output icache_pkg::addr_t rd_addr,
    input  logic              ret_valid,
    input  icache_pkg::line_t ret_data,
    output logic              flush_out,
    // uncached port
    output logic              uc_ren,
    output icache_pkg::addr_t uc_addr,
    input  logic              uc_rvalid,
    input  icache_pkg::word_t uc_rdata
);

    icache u_icache (
        .clk          (clk),
        .reset        (reset),
        .fetch_en     (fetch_en),
        .uncache_en   (uncache_en),
        .pc           (pc),
        .branch_flush (branch_flush),
        .stall        (stall),
        .inst_valid   (inst_valid),
        .inst_b_valid (inst_b_valid),
        .inst_a       (inst_a),
        .inst_b       (inst_b),
        .pc_out       (pc_out),
        .rd_req       (rd_req),
        .rd_addr      (rd_addr),
        .ret_valid    (ret_valid),
        .ret_data     (ret_data),
        .flush_out    (flush_out),
        .uc_ren       (uc_ren),
        .uc_addr      (uc_addr),
        .uc_rvalid    (uc_rvalid),
        .uc_rdata     (uc_rdata)
    );

endmodule

//--- icache_way.sv
`include "icache_settings.svh"

module icache_way (
    input  logic                       clk,
    input  icache_pkg::index_t         addra,
    input  icache_pkg::index_t         addrb,
    input  logic                       wea,
    input  logic                       web,
    input  icache_pkg::line_t          line_in,
    input  icache_pkg::tag_t           tag_in,
    output icache_pkg::line_t          data_a,
    output icache_pkg::line_t          data_b,
    output logic [`ICACHE_TAG_SIZE:0]  tagv_a,
    output logic [`ICACHE_TAG_SIZE:0]  tagv_b
);
    import icache_pkg::*;

    word_t tagv_wr;
    word_t tagv_rd_a, tagv_rd_b;

    // one bank per word of the line
    for (genvar i = 0; i < `ICACHE_BANK_NUM; i++) begin : g_bank
        icache_bram u_bank (
            .clk   (clk),
            .wea   (wea),
            .addra (addra),
            .dina  (line_in[i*`ICACHE_DATA_SIZE +: `ICACHE_DATA_SIZE]),
            .douta (data_a[i*`ICACHE_DATA_SIZE +: `ICACHE_DATA_SIZE]),
            .web   (web),
            .addrb (addrb),
            .dinb  (line_in[i*`ICACHE_DATA_SIZE +: `ICACHE_DATA_SIZE]),
            .doutb (data_b[i*`ICACHE_DATA_SIZE +: `ICACHE_DATA_SIZE])
        );
    end

    // a refill strobes one port and marks the entry valid,
    // both strobes together is the clear pass and leaves it invalid
    assign tagv_wr = word_t'({~(wea & web), tag_in});

    icache_bram u_tagv (
        .clk   (clk),
        .wea   (wea),
        .addra (addra),
        .dina  (tagv_wr),
        .douta (tagv_rd_a),
        .web   (web),
        .addrb (addrb),
        .dinb  (tagv_wr),
        .doutb (tagv_rd_b)
    );

    assign tagv_a = tagv_rd_a[`ICACHE_TAG_SIZE:0];   // {valid, tag}
    assign tagv_b = tagv_rd_b[`ICACHE_TAG_SIZE:0];

endmodule
